// ==== cfg_pkg.sv ====
package cfg_pkg;

    // ------------------------------------------------------------
    // Field widths
    // ------------------------------------------------------------
    // Address offset, also the width of the sequence number
    parameter int ADDR_W  = 16;
    parameter int SHIFT_W = 4;
    parameter int DATA_W  = 32;
    parameter int HOPS_W  = 8;
    parameter int KIND_W  = 4;

    // ------------------------------------------------------------
    // Buffer kind codes
    // ------------------------------------------------------------
    // Only the two setup kinds are kept by the filter
    parameter logic [KIND_W-1:0] KIND_CU_SETUP     = 4'd2;
    parameter logic [KIND_W-1:0] KIND_ENGINE_SETUP = 4'd3;

    // ------------------------------------------------------------
    // Engine window
    // ------------------------------------------------------------
    // Slots per engine, one mask bit each
    parameter int SEQ_SLOTS = 16;
    parameter int SEQ_IDX_W = 4;

    // ------------------------------------------------------------
    // Response data word
    // ------------------------------------------------------------
    // Setup view of a response word, hop count in the low bits
    typedef struct packed {
        logic [DATA_W-HOPS_W-1:0] unused;
        logic [HOPS_W-1:0]        hops;
    } setup_word_t;

    // Raw word as moved by the filter and FIFO, setup view in slot 0
    typedef union packed {
        logic [DATA_W-1:0] raw;
        setup_word_t       setup;
    } data_word_u;

endpackage : cfg_pkg

// ==== sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH       = 8,
    parameter int DEPTH       = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic             ap_clk,
    input  logic             areset_csr_index_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_ok;
    logic             rd_ok;

    // Wrap at DEPTH, so depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Writes into a full FIFO and reads from an empty one are ignored
    assign wr_ok = wr_en & ~full;
    assign rd_ok = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= ptr_next(wr_ptr);
            if (rd_ok) rd_ptr <= ptr_next(rd_ptr);
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (wr_ok) mem[wr_ptr] <= din;
    end

    // Show-ahead head word
    assign dout      = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(DEPTH));
    assign prog_full = (count >= CNT_W'(PROG_THRESH));

endmodule : sync_fifo

// ==== response_filter.sv ====
`timescale 1ns/1ps

module response_filter #(
    parameter int ID_RELATIVE = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  logic                           resp_valid,
    input  logic [cfg_pkg::KIND_W-1:0]     resp_kind,
    input  logic [cfg_pkg::ADDR_W-1:0]     resp_offset,
    input  logic [cfg_pkg::SHIFT_W-1:0]    resp_shift,
    input  cfg_pkg::data_word_u            resp_data,
    input  logic                           resp_ready,
    output logic                           push,
    output logic [cfg_pkg::SEQ_IDX_W-1:0]  push_slot,
    output cfg_pkg::data_word_u            push_data
);

    // First sequence number of this engine's window
    localparam logic [cfg_pkg::ADDR_W-1:0] SEQ_MIN =
        cfg_pkg::ADDR_W'(ID_RELATIVE * cfg_pkg::SEQ_SLOTS);

    logic                          in_valid;
    logic [cfg_pkg::KIND_W-1:0]    in_kind;
    logic [cfg_pkg::ADDR_W-1:0]    in_offset;
    logic [cfg_pkg::SHIFT_W-1:0]   in_shift;
    cfg_pkg::data_word_u           in_data;
    logic [cfg_pkg::ADDR_W-1:0]    seq;
    logic [cfg_pkg::ADDR_W-1:0]    seq_rel;
    logic                          kind_ok;
    logic                          in_window;

    // ------------------------------------------------------------
    // Input register stage
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            in_valid <= 1'b0;
        end else begin
            in_valid <= resp_valid & resp_ready;
        end
    end

    always_ff @(posedge ap_clk) begin
        in_kind   <= resp_kind;
        in_offset <= resp_offset;
        in_shift  <= resp_shift;
        in_data   <= resp_data;
    end

    // ------------------------------------------------------------
    // Sequence number and filter
    // ------------------------------------------------------------
    assign seq     = in_offset >> in_shift;
    assign seq_rel = seq - SEQ_MIN;
    assign kind_ok = (in_kind == cfg_pkg::KIND_CU_SETUP) ||
                     (in_kind == cfg_pkg::KIND_ENGINE_SETUP);
    // Relative compare keeps the upper bound free of overflow
    assign in_window = (seq >= SEQ_MIN) && (seq_rel < cfg_pkg::ADDR_W'(cfg_pkg::SEQ_SLOTS));

    assign push      = in_valid & kind_ok & in_window;
    assign push_slot = seq_rel[cfg_pkg::SEQ_IDX_W-1:0];
    assign push_data = in_data;

endmodule : response_filter

// ==== config_collector.sv ====
`timescale 1ns/1ps

module config_collector (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  logic                           slot_valid,
    input  logic [cfg_pkg::SEQ_IDX_W-1:0]  slot,
    input  cfg_pkg::data_word_u            slot_data,
    input  logic                           out_prog_full,
    output logic                           slot_pop,
    output logic                           cfg_push,
    output logic [cfg_pkg::HOPS_W-1:0]     cfg_push_hops
);

    logic [cfg_pkg::SEQ_SLOTS-1:0] slot_mask;
    logic [cfg_pkg::HOPS_W-1:0]    hops_reg;
    logic                          mask_full;

    // ------------------------------------------------------------
    // Pop control
    // ------------------------------------------------------------
    assign mask_full = &slot_mask;

    // Hold the response FIFO while a finished window is emitted
    // or the output FIFO is close to full
    assign slot_pop = slot_valid & ~mask_full & ~out_prog_full;

    // ------------------------------------------------------------
    // Slot mask and emission
    // ------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            slot_mask <= '0;
            cfg_push  <= 1'b0;
        end else begin
            cfg_push <= mask_full;
            if (mask_full) begin
                // Window complete, start collecting the next one
                slot_mask <= '0;
            end else if (slot_pop) begin
                slot_mask[slot] <= 1'b1;
            end
        end
    end

    // Hop count comes from slot 0 only, a repeat slot 0 overwrites it
    always_ff @(posedge ap_clk) begin
        if (slot_pop && (slot == '0)) begin
            hops_reg <= slot_data.setup.hops;
        end
    end

    // Stable through the push cycle since slot 0 pops are
    // blocked while the mask is full
    assign cfg_push_hops = hops_reg;

endmodule : config_collector

// ==== forward_config_memory.sv ====
`timescale 1ns/1ps

module forward_config_memory #(
    parameter int ID_RELATIVE = 0,
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                         ap_clk,
    input  logic                         areset_csr_index_generator,
    input  logic                         resp_valid,
    input  logic [cfg_pkg::KIND_W-1:0]   resp_kind,
    input  logic [cfg_pkg::ADDR_W-1:0]   resp_offset,
    input  logic [cfg_pkg::SHIFT_W-1:0]  resp_shift,
    input  cfg_pkg::data_word_u          resp_data,
    input  logic                         cfg_ready,
    output logic                         resp_ready,
    output logic                         cfg_valid,
    output logic [cfg_pkg::HOPS_W-1:0]   cfg_hops
);

    localparam int RESP_W = cfg_pkg::SEQ_IDX_W + cfg_pkg::DATA_W;

    // Filter to response FIFO
    logic                          filt_push;
    logic [cfg_pkg::SEQ_IDX_W-1:0] filt_slot;
    cfg_pkg::data_word_u           filt_data;

    // Response FIFO to collector
    logic [RESP_W-1:0]             resp_dout;
    logic                          resp_empty;
    logic                          resp_prog_full;
    logic                          resp_pop;
    logic [cfg_pkg::SEQ_IDX_W-1:0] head_slot;
    cfg_pkg::data_word_u           head_data;

    // Collector to output FIFO
    logic                          coll_push;
    logic [cfg_pkg::HOPS_W-1:0]    coll_hops;
    logic                          out_empty;
    logic                          out_prog_full;

    // ------------------------------------------------------------
    // Stream handshakes
    // ------------------------------------------------------------
    // Threshold at depth minus 4 covers words still in the filter stage
    assign resp_ready = ~resp_prog_full;
    assign cfg_valid  = ~out_empty;

    response_filter #(
        .ID_RELATIVE(ID_RELATIVE)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_kind                 (resp_kind),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .resp_ready                (resp_ready),
        .push                      (filt_push),
        .push_slot                 (filt_slot),
        .push_data                 (filt_data)
    );

    // Slot index in the top bits, data word below
    sync_fifo #(
        .WIDTH      (RESP_W),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(FIFO_DEPTH - 4)
    ) u_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (filt_push),
        .din                       ({filt_slot, filt_data}),
        .rd_en                     (resp_pop),
        .dout                      (resp_dout),
        .empty                     (resp_empty),
        .full                      (),
        .prog_full                 (resp_prog_full)
    );

    assign head_slot = resp_dout[RESP_W-1 -: cfg_pkg::SEQ_IDX_W];
    assign head_data = resp_dout[cfg_pkg::DATA_W-1:0];

    config_collector u_collector (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .slot_valid                (~resp_empty),
        .slot                      (head_slot),
        .slot_data                 (head_data),
        .out_prog_full             (out_prog_full),
        .slot_pop                  (resp_pop),
        .cfg_push                  (coll_push),
        .cfg_push_hops             (coll_hops)
    );

    // Output FIFO pops on each cfg transfer
    sync_fifo #(
        .WIDTH      (cfg_pkg::HOPS_W),
        .DEPTH      (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_out_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (coll_push),
        .din                       (coll_hops),
        .rd_en                     (cfg_valid & cfg_ready),
        .dout                      (cfg_hops),
        .empty                     (out_empty),
        .full                      (),
        .prog_full                 (out_prog_full)
    );

endmodule : forward_config_memory

// ==== tb_forward_config_memory.sv ====
`timescale 1ns/1ps

module tb_forward_config_memory;

    localparam int WIN_BASE      = 16;
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 500;

    // One stimulus row, accept is the expected filter decision
    typedef struct packed {
        logic [cfg_pkg::KIND_W-1:0]  kind;
        logic [cfg_pkg::ADDR_W-1:0]  offset;
        logic [cfg_pkg::SHIFT_W-1:0] shift;
        logic [cfg_pkg::DATA_W-1:0]  data;
        logic                        accept;
    } row_t;

    logic                          ap_clk;
    logic                          areset_csr_index_generator;
    logic                          resp_valid;
    logic [cfg_pkg::KIND_W-1:0]    resp_kind;
    logic [cfg_pkg::ADDR_W-1:0]    resp_offset;
    logic [cfg_pkg::SHIFT_W-1:0]   resp_shift;
    cfg_pkg::data_word_u           resp_data;
    logic                          cfg_ready;
    logic                          resp_ready;
    logic                          cfg_valid;
    logic [cfg_pkg::HOPS_W-1:0]    cfg_hops;

    row_t                          rows[$];
    logic [cfg_pkg::HOPS_W-1:0]    exp_q[$];
    logic [cfg_pkg::SEQ_SLOTS-1:0] model_mask;
    logic [cfg_pkg::HOPS_W-1:0]    model_hops;
    // Sink mode: 0 ready high, 1 ready low, 2 random
    int                            ready_mode;

    forward_config_memory #(
        .ID_RELATIVE(1)
    ) UUT (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_kind                 (resp_kind),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .cfg_ready                 (cfg_ready),
        .resp_ready                (resp_ready),
        .cfg_valid                 (cfg_valid),
        .cfg_hops                  (cfg_hops)
    );

    initial begin
        ap_clk = 1'b0;
        forever #50 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------
    // Checks and scoreboard
    // ------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

    // Reference collector, a full window emits the latest slot 0 hop count
    task automatic model_accept(input row_t r);
        int slot;
        slot = int'(r.offset >> r.shift) - WIN_BASE;
        if (slot == 0) begin
            model_hops = r.data[cfg_pkg::HOPS_W-1:0];
        end
        model_mask[4'(slot)] = 1'b1;
        if (&model_mask) begin
            exp_q.push_back(model_hops);
            model_mask = '0;
        end
    endtask

    always @(posedge ap_clk) begin
        if (!areset_csr_index_generator && cfg_valid && cfg_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("Unexpected configuration on the output stream");
            end else begin
                check_equal(32'(cfg_hops), 32'(exp_q.pop_front()), "cfg_hops");
            end
        end
    end

    // Sink side, driven just after the clock edge
    initial begin
        logic [31:0] r;
        cfg_ready = 1'b1;
        forever begin
            @(posedge ap_clk);
            #1;
            if (ready_mode == 1) begin
                cfg_ready = 1'b0;
            end else if (ready_mode == 2) begin
                r = $urandom;
                cfg_ready = r[0];
            end else begin
                cfg_ready = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    function automatic row_t make_row(input logic [3:0] kind, input logic [15:0] offset,
                                      input logic [3:0] shift, input logic [31:0] data,
                                      input logic accept);
        row_t r;
        r.kind   = kind;
        r.offset = offset;
        r.shift  = shift;
        r.data   = data;
        r.accept = accept;
        return r;
    endfunction

    // Sixteen in-window rows, slot 0 carries the hop count
    task automatic add_window(input logic [3:0] kind, input logic [7:0] hops,
                              input logic shuffle);
        int          order[$];
        int          j;
        int          t;
        logic [31:0] data;
        for (int i = 0; i < cfg_pkg::SEQ_SLOTS; i++) begin
            order.push_back(i);
        end
        for (int i = cfg_pkg::SEQ_SLOTS - 1; i > 0 && shuffle; i--) begin
            j = int'($urandom % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < cfg_pkg::SEQ_SLOTS; i++) begin
            data = $urandom;
            if (order[i] == 0) begin
                data[cfg_pkg::HOPS_W-1:0] = hops;
            end
            rows.push_back(make_row(kind, 16'(WIN_BASE + order[i]), 4'd0, data, 1'b1));
        end
    endtask

    task automatic apply_row(input row_t r);
        int n;
        n = 0;
        while (!resp_ready) begin
            if (n >= READY_TIMEOUT) begin
                abort_run("Timeout: resp_ready stayed low while sending a word");
            end else begin
                @(posedge ap_clk);
                #1;
                n++;
            end
        end
        resp_valid  = 1'b1;
        resp_kind   = r.kind;
        resp_offset = r.offset;
        resp_shift  = r.shift;
        resp_data.raw = r.data;
        @(posedge ap_clk);
        #1;
        resp_valid = 1'b0;
        if (r.accept) begin
            model_accept(r);
        end
    endtask

    task automatic run_rows();
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        rows.delete();
    endtask

    // ------------------------------------------------------------
    // Waits
    // ------------------------------------------------------------
    task automatic wait_cfg_valid();
        int n;
        n = 0;
        while (!cfg_valid) begin
            if (n >= DRAIN_TIMEOUT) begin
                abort_run("Timeout: cfg_valid never went high");
            end else begin
                @(posedge ap_clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n >= DRAIN_TIMEOUT) begin
                abort_run("Timeout: expected configurations did not come out");
            end else begin
                @(posedge ap_clk);
                #1;
                n++;
            end
        end
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(posedge ap_clk);
            #1;
            check_equal(32'(cfg_valid), 32'd0, "cfg_valid with no window complete");
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        row_t        tmp;
        logic [31:0] r;
        logic [7:0]  hop_a;
        void'($urandom(32'h2c544eb8));
        areset_csr_index_generator = 1'b1;
        resp_valid    = 1'b0;
        resp_kind     = '0;
        resp_offset   = '0;
        resp_shift    = '0;
        resp_data.raw = '0;
        ready_mode    = 0;
        model_mask    = '0;
        model_hops    = '0;
        repeat (3) @(posedge ap_clk);
        #1;
        areset_csr_index_generator = 1'b0;

        check_equal(32'(cfg_valid), 32'd0, "cfg_valid after reset");
        check_equal(32'(resp_ready), 32'd1, "resp_ready after reset");

        // Window in slot order
        add_window(cfg_pkg::KIND_CU_SETUP, 8'h3c, 1'b0);
        run_rows();
        wait_drain();

        // Shuffled window with a repeated slot 0 ahead of the last word
        r = $urandom;
        hop_a = r[7:0];
        add_window(cfg_pkg::KIND_ENGINE_SETUP, hop_a, 1'b1);
        if (rows[15].offset == 16'(WIN_BASE)) begin
            tmp = rows[15];
            rows[15] = rows[14];
            rows[14] = tmp;
        end
        r = $urandom;
        rows.insert(15, make_row(cfg_pkg::KIND_CU_SETUP, 16'(WIN_BASE), 4'd0,
                                 {r[31:8], ~hop_a}, 1'b1));
        run_rows();
        wait_drain();

        // Filter rows, then slots 2 to 15 reached through shifts
        rows.push_back(make_row(4'd0, 16'd16, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(4'd5, 16'd17, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_CU_SETUP, 16'd15, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_CU_SETUP, 16'd32, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_CU_SETUP, 16'hffff, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_ENGINE_SETUP, 16'd68, 4'd0, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_CU_SETUP, 16'd20, 4'd1, $urandom, 1'b0));
        rows.push_back(make_row(cfg_pkg::KIND_CU_SETUP, 16'd256, 4'd3, $urandom, 1'b0));
        for (int s = 2; s < cfg_pkg::SEQ_SLOTS; s++) begin
            rows.push_back(make_row(4'(2 + s % 2), 16'((WIN_BASE + s) << (s % 4)),
                                    4'(s % 4), $urandom, 1'b1));
        end
        run_rows();
        check_quiet(DRAIN_TIMEOUT);
        // Slots 0 and 1 reach the window only through a shift of 2
        rows.push_back(make_row(cfg_pkg::KIND_ENGINE_SETUP, 16'd64, 4'd2, 32'h1234_5691,
                                1'b1));
        rows.push_back(make_row(cfg_pkg::KIND_ENGINE_SETUP, 16'd68, 4'd2, 32'h0000_0077,
                                1'b1));
        run_rows();
        wait_drain();

        // Three windows under back-pressure
        ready_mode = 1;
        add_window(cfg_pkg::KIND_CU_SETUP, 8'h11, 1'b1);
        add_window(cfg_pkg::KIND_ENGINE_SETUP, 8'h22, 1'b1);
        add_window(cfg_pkg::KIND_CU_SETUP, 8'h33, 1'b1);
        run_rows();
        wait_cfg_valid();
        ready_mode = 2;
        wait_drain();
        ready_mode = 0;

        check_quiet(20);
        if (exp_q.size() != 0 || model_mask != '0) begin
            abort_run("Run ended with configurations still outstanding");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
cfg_pkg.sv
sync_fifo.sv
response_filter.sv
config_collector.sv
forward_config_memory.sv
tb_forward_config_memory.sv

// ==== Makefile ====
# Verilator build and run for the forwarding-engine configuration receiver

VERILATOR ?= verilator
TOP       ?= tb_forward_config_memory
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "Test OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
